// File: hw/mm_pkg.sv
package mm_pkg;

    // Matrix and datapath sizes
    localparam int MAT_DIM    = 4;
    localparam int DATA_W     = 32;
    localparam int ELEM_W     = 8;
    localparam int ACC_W      = 32;
    localparam int SP_ADDR_W  = 8;
    localparam int STRIDE_W   = 8;
    localparam int LANE_W     = 2;
    localparam int APB_ADDR_W = 12;

    // CSR word indices, PADDR[5:2]
    typedef enum logic [3:0] {
        CSR_START    = 4'd0,
        CSR_MAT_A    = 4'd1,
        CSR_MAT_B    = 4'd2,
        CSR_MAT_C    = 4'd3,
        CSR_STRIDE_A = 4'd4,
        CSR_STRIDE_B = 4'd5,
        CSR_STRIDE_C = 4'd6,
        CSR_STATUS   = 4'd7
    } csr_addr_t;

    typedef enum logic [1:0] {
        IDLE         = 2'b00,
        SETUP        = 2'b01,
        READ_ACCESS  = 2'b10,
        WRITE_ACCESS = 2'b11
    } apb_state_t;

    typedef enum logic [1:0] {
        FEED_IDLE = 2'b00,
        FEED_A    = 2'b01,
        FEED_B    = 2'b10,
        FEED_WAIT = 2'b11
    } feed_state_t;

    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_ROW  = 2'b01,
        WR_DONE = 2'b10
    } wr_state_t;

endpackage

// File: hw/apb_csr.sv
`timescale 1ns/1ps

module apb_csr
    import mm_pkg::*;
(
    input  logic                  apb,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]     pwdata,
    output logic [DATA_W-1:0]     prdata,
    output logic                  pready,
    output logic                  start,
    output logic [SP_ADDR_W-1:0]  base_a,
    output logic [SP_ADDR_W-1:0]  base_b,
    output logic [SP_ADDR_W-1:0]  base_c,
    output logic [STRIDE_W-1:0]   stride_a,
    output logic [STRIDE_W-1:0]   stride_b,
    output logic [STRIDE_W-1:0]   stride_c,
    input  logic                  done,
    output logic                  mem_en,
    output logic                  mem_we,
    output logic [SP_ADDR_W-1:0]  mem_addr,
    output logic [DATA_W-1:0]     mem_wdata,
    input  logic [DATA_W-1:0]     mem_rdata
);

    apb_state_t state, next_state;
    csr_addr_t  csr_idx;
    logic       sp_sel;
    logic       wr_fire;
    logic       rd_access;
    logic       busy;
    logic       done_flag;
    logic [DATA_W-1:0] csr_rdata;

    assign pready    = 1'b1;
    assign sp_sel    = paddr[11];
    assign csr_idx   = csr_addr_t'(paddr[5:2]);
    assign wr_fire   = (next_state == WRITE_ACCESS);
    assign rd_access = (next_state == READ_ACCESS);

    always_ff @(posedge apb) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Back-to-back transfers go straight from access to setup
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (psel && !penable)
                    next_state = SETUP;
            end
            SETUP: begin
                if (psel && penable)
                    next_state = pwrite ? WRITE_ACCESS : READ_ACCESS;
                else if (!psel)
                    next_state = IDLE;
            end
            READ_ACCESS, WRITE_ACCESS: begin
                next_state = (psel && !penable) ? SETUP : IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Scratchpad read goes out in setup, write at the access edge
    assign mem_en    = sp_sel && ((next_state == SETUP && !pwrite) || wr_fire);
    assign mem_we    = sp_sel && wr_fire;
    assign mem_addr  = paddr[9:2];
    assign mem_wdata = pwdata;

    always_ff @(posedge apb) begin
        if (reset) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            base_a    <= '0;
            base_b    <= '0;
            base_c    <= '0;
            stride_a  <= '0;
            stride_b  <= '0;
            stride_c  <= '0;
        end else begin
            start <= wr_fire && !sp_sel && csr_idx == CSR_START && pwdata[0] && !busy && !start;
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
            if (wr_fire && !sp_sel) begin
                case (csr_idx)
                    CSR_MAT_A:    base_a   <= pwdata[SP_ADDR_W-1:0];
                    CSR_MAT_B:    base_b   <= pwdata[SP_ADDR_W-1:0];
                    CSR_MAT_C:    base_c   <= pwdata[SP_ADDR_W-1:0];
                    CSR_STRIDE_A: stride_a <= pwdata[STRIDE_W-1:0];
                    CSR_STRIDE_B: stride_b <= pwdata[STRIDE_W-1:0];
                    CSR_STRIDE_C: stride_c <= pwdata[STRIDE_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // START and unmapped indices read zero
    always_comb begin
        case (csr_idx)
            CSR_MAT_A:    csr_rdata = DATA_W'(base_a);
            CSR_MAT_B:    csr_rdata = DATA_W'(base_b);
            CSR_MAT_C:    csr_rdata = DATA_W'(base_c);
            CSR_STRIDE_A: csr_rdata = DATA_W'(stride_a);
            CSR_STRIDE_B: csr_rdata = DATA_W'(stride_b);
            CSR_STRIDE_C: csr_rdata = DATA_W'(stride_c);
            CSR_STATUS:   csr_rdata = DATA_W'({busy, done_flag});
            default:      csr_rdata = '0;
        endcase
    end

    assign prdata = !rd_access ? '0 : (sp_sel ? mem_rdata : csr_rdata);

endmodule

// File: hw/scratchpad.sv
`timescale 1ns/1ps

module scratchpad
    import mm_pkg::*;
(
    input  logic                 apb,
    // APB side
    input  logic                 mem_en,
    input  logic                 mem_we,
    input  logic [SP_ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0]    mem_wdata,
    output logic [DATA_W-1:0]    mem_rdata,
    // Engine read
    input  logic                 rd_req,
    input  logic [SP_ADDR_W-1:0] rd_addr,
    output logic                 rd_grant,
    output logic [DATA_W-1:0]    rd_data,
    // Engine write
    input  logic                 wr_en,
    input  logic [SP_ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0]    wr_data
);

    logic [DATA_W-1:0] mem [0:2**SP_ADDR_W-1];

    // Engine port serves one access per cycle, writes first
    assign rd_grant = rd_req && !wr_en;

    always_ff @(posedge apb) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge apb) begin
        if (rd_grant) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder
    import mm_pkg::*;
(
    input  logic                     apb,
    input  logic                     reset,
    input  logic                     start,
    input  logic [SP_ADDR_W-1:0]     base_a,
    input  logic [SP_ADDR_W-1:0]     base_b,
    input  logic [STRIDE_W-1:0]      stride_a,
    input  logic [STRIDE_W-1:0]      stride_b,
    output logic                     rd_req,
    output logic [SP_ADDR_W-1:0]     rd_addr,
    input  logic                     rd_grant,
    input  logic [DATA_W-1:0]        rd_data,
    input  logic [MAT_DIM-1:0]       res_valid,
    output logic                     op_valid,
    output logic [LANE_W-1:0]        op_lane,
    output logic signed [ELEM_W-1:0] op_a,
    output logic signed [ELEM_W-1:0] op_b,
    output logic                     op_first,
    output logic                     op_last
);

    feed_state_t state;
    logic [LANE_W-1:0]    row, k, lane;
    logic [SP_ADDR_W-1:0] a_row, b_row;
    logic                 pend_valid, pend_is_a, pend_first, pend_last;
    logic [LANE_W-1:0]    pend_lane;
    logic signed [ELEM_W-1:0] a_reg;

    assign rd_req  = (state == FEED_A) || (state == FEED_B);
    assign rd_addr = (state == FEED_A) ? a_row + SP_ADDR_W'(k) : b_row + SP_ADDR_W'(lane);

    always_ff @(posedge apb) begin
        if (reset) begin
            state      <= FEED_IDLE;
            pend_valid <= 1'b0;
            row        <= '0;
            k          <= '0;
            lane       <= '0;
            a_row      <= '0;
            b_row      <= '0;
        end else begin
            pend_valid <= rd_req && rd_grant;
            case (state)
                FEED_IDLE: if (start) begin
                    state <= FEED_A;
                    row   <= '0;
                    k     <= '0;
                    lane  <= '0;
                    a_row <= base_a;
                    b_row <= base_b;
                end
                FEED_A: if (rd_grant) begin
                    state <= FEED_B;
                    lane  <= '0;
                end
                FEED_B: if (rd_grant) begin
                    lane <= lane + 1'b1;
                    if (lane == LANE_W'(MAT_DIM - 1)) begin
                        if (k == LANE_W'(MAT_DIM - 1)) begin
                            k     <= '0;
                            row   <= row + 1'b1;
                            a_row <= a_row + stride_a;
                            b_row <= base_b;
                            state <= (row == LANE_W'(MAT_DIM - 1)) ? FEED_IDLE : FEED_A;
                        end else begin
                            k     <= k + 1'b1;
                            b_row <= b_row + stride_b;
                            // Last k overwrites the held results, so wait for the take
                            state <= (k == LANE_W'(MAT_DIM - 2)) ? FEED_WAIT : FEED_A;
                        end
                    end
                end
                FEED_WAIT: if (!(|res_valid)) state <= FEED_A;
                default: state <= FEED_IDLE;
            endcase
        end
    end

    // Tag of the read in flight, data returns next cycle
    always_ff @(posedge apb) begin
        pend_is_a  <= (state == FEED_A);
        pend_lane  <= lane;
        pend_first <= (k == '0);
        pend_last  <= (k == LANE_W'(MAT_DIM - 1));
        if (pend_valid && pend_is_a) begin
            a_reg <= rd_data[ELEM_W-1:0];
        end
    end

    assign op_valid = pend_valid && !pend_is_a;
    assign op_lane  = pend_lane;
    assign op_a     = a_reg;
    assign op_b     = rd_data[ELEM_W-1:0];
    assign op_first = pend_first;
    assign op_last  = pend_last;

endmodule

// File: hw/mac_lane.sv
`timescale 1ns/1ps

module mac_lane
    import mm_pkg::*;
#(
    parameter int LANE_INDEX = 0
) (
    input  logic                     apb,
    input  logic                     reset,
    input  logic                     op_valid,
    input  logic [LANE_W-1:0]        op_lane,
    input  logic signed [ELEM_W-1:0] op_a,
    input  logic signed [ELEM_W-1:0] op_b,
    input  logic                     op_first,
    input  logic                     op_last,
    input  logic                     res_take,
    output logic                     res_valid,
    output logic signed [ACC_W-1:0]  res_value
);

    logic                      hit;
    logic signed [2*ELEM_W-1:0] product;
    logic signed [ACC_W-1:0]   product_ext;
    logic signed [ACC_W-1:0]   acc;
    logic signed [ACC_W-1:0]   sum;

    assign hit         = op_valid && (op_lane == LANE_W'(LANE_INDEX));
    assign product     = op_a * op_b;
    assign product_ext = product;
    assign sum         = (op_first ? '0 : acc) + product_ext;

    always_ff @(posedge apb) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (hit && op_last) begin
            res_valid <= 1'b1;
        end else if (res_take) begin
            res_valid <= 1'b0;
        end
    end

    // Held result frees the accumulator for the next row
    always_ff @(posedge apb) begin
        if (hit) begin
            acc <= sum;
            if (op_last) res_value <= sum;
        end
    end

endmodule

// File: hw/result_writer.sv
`timescale 1ns/1ps

module result_writer
    import mm_pkg::*;
(
    input  logic                     apb,
    input  logic                     reset,
    input  logic                     start,
    input  logic [SP_ADDR_W-1:0]     base_c,
    input  logic [STRIDE_W-1:0]      stride_c,
    input  logic [MAT_DIM-1:0]       res_valid,
    input  logic [MAT_DIM*ACC_W-1:0] res_value,
    output logic                     res_take,
    output logic                     wr_en,
    output logic [SP_ADDR_W-1:0]     wr_addr,
    output logic [DATA_W-1:0]        wr_data,
    output logic                     done
);

    wr_state_t state;
    logic                 draining;
    logic [LANE_W-1:0]    row, col;
    logic [SP_ADDR_W-1:0] c_row;

    always_ff @(posedge apb) begin
        if (reset) begin
            state    <= WR_IDLE;
            draining <= 1'b0;
            res_take <= 1'b0;
            row      <= '0;
            col      <= '0;
            c_row    <= '0;
        end else begin
            res_take <= 1'b0;
            case (state)
                WR_IDLE: if (start) begin
                    state <= WR_ROW;
                    row   <= '0;
                    c_row <= base_c;
                end
                WR_ROW: begin
                    if (draining) begin
                        col <= col + 1'b1;
                        if (col == LANE_W'(MAT_DIM - 1)) begin
                            draining <= 1'b0;
                            res_take <= 1'b1;
                            row      <= row + 1'b1;
                            c_row    <= c_row + stride_c;
                            if (row == LANE_W'(MAT_DIM - 1)) state <= WR_DONE;
                        end
                    end else if (&res_valid && !res_take) begin
                        // Flags still high while the take is in flight
                        draining <= 1'b1;
                        col      <= '0;
                    end
                end
                WR_DONE: state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    assign wr_en   = draining;
    assign wr_addr = c_row + SP_ADDR_W'(col);
    assign wr_data = res_value[col*ACC_W +: ACC_W];
    assign done    = (state == WR_DONE);

endmodule

// File: hw/mm_accel_top.sv
`timescale 1ns/1ps

module mm_accel_top
    import mm_pkg::*;
(
    input  logic                  apb,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]     pwdata,
    output logic [DATA_W-1:0]     prdata,
    output logic                  pready
);

    logic                     start, done;
    logic [SP_ADDR_W-1:0]     base_a, base_b, base_c;
    logic [STRIDE_W-1:0]      stride_a, stride_b, stride_c;
    logic                     mem_en, mem_we;
    logic [SP_ADDR_W-1:0]     mem_addr;
    logic [DATA_W-1:0]        mem_wdata, mem_rdata;
    logic                     rd_req, rd_grant;
    logic [SP_ADDR_W-1:0]     rd_addr;
    logic [DATA_W-1:0]        rd_data;
    logic                     wr_en;
    logic [SP_ADDR_W-1:0]     wr_addr;
    logic [DATA_W-1:0]        wr_data;
    logic                     op_valid, op_first, op_last;
    logic [LANE_W-1:0]        op_lane;
    logic signed [ELEM_W-1:0] op_a, op_b;
    logic [MAT_DIM-1:0]       res_valid;
    logic [MAT_DIM*ACC_W-1:0] res_value;
    logic                     res_take;

    apb_csr u_csr (.*);

    scratchpad u_scratchpad (.*);

    operand_feeder u_feeder (.*);

    // One lane per output column
    for (genvar g = 0; g < MAT_DIM; g++) begin : g_lane
        mac_lane #(.LANE_INDEX(g)) u_lane (
            .apb       (apb),
            .reset     (reset),
            .op_valid  (op_valid),
            .op_lane   (op_lane),
            .op_a      (op_a),
            .op_b      (op_b),
            .op_first  (op_first),
            .op_last   (op_last),
            .res_take  (res_take),
            .res_valid (res_valid[g]),
            .res_value (res_value[g*ACC_W +: ACC_W])
        );
    end

    result_writer u_writer (.*);

endmodule

// File: verification/tb_mm_accel.sv
`timescale 1ns/1ps

module tb_mm_accel
    import mm_pkg::*;
();

    logic                  apb;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [DATA_W-1:0]     pwdata;
    logic [DATA_W-1:0]     prdata;
    logic                  pready;

    integer seed = 32'hf4c3_ed00;

    // Shadow of the scratchpad as the CPU wrote it
    logic [DATA_W-1:0]    sp_model [0:255];
    logic [SP_ADDR_W-1:0] cur_base_a, cur_base_b;
    logic [STRIDE_W-1:0]  cur_stride_a, cur_stride_b;

    // Pending comparisons
    string             name_q[$];
    logic [DATA_W-1:0] exp_q[$];
    logic [DATA_W-1:0] act_q[$];

    mm_accel_top dut (.*);

    always #2 apb = ~apb;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected)
            fail_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    endtask

    always @(negedge apb) begin
        while (exp_q.size() > 0)
            check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    task automatic expect_value(input string name, input logic [DATA_W-1:0] expected,
                                input logic [DATA_W-1:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    function automatic logic [APB_ADDR_W-1:0] csr_paddr(input logic [3:0] idx);
        return {6'b0, idx, 2'b00};
    endfunction

    function automatic logic [APB_ADDR_W-1:0] sp_paddr(input logic [SP_ADDR_W-1:0] addr);
        return {2'b10, addr, 2'b00};
    endfunction

    // Element address, wraps modulo 256
    function automatic logic [SP_ADDR_W-1:0] elem_addr(input logic [SP_ADDR_W-1:0] base,
            input logic [STRIDE_W-1:0] stride, input int row, input int col);
        return SP_ADDR_W'(base + row * stride + col);
    endfunction

    // One element of C from the shadow copies of A and B
    function automatic logic [DATA_W-1:0] ref_matmul(input int i, input int j);
        logic signed [31:0] sum;
        logic signed [7:0]  a_el;
        logic signed [7:0]  b_el;
        sum = 0;
        for (int k = 0; k < MAT_DIM; k++) begin
            a_el = sp_model[elem_addr(cur_base_a, cur_stride_a, i, k)][7:0];
            b_el = sp_model[elem_addr(cur_base_b, cur_stride_b, k, j)][7:0];
            sum  = sum + a_el * b_el;
        end
        return sum;
    endfunction

    // Called 1 ns after a rising edge, returns 1 ns after the access edge
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge apb);
        #1 penable = 1'b1;
        @(posedge apb);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge apb);
        #1 penable = 1'b1;
        #1 data = prdata;
        expect_value("pready", 1'b1, pready);
        @(posedge apb);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic sp_write(input logic [SP_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        sp_model[addr] = data;
        apb_write(sp_paddr(addr), data);
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] status;
        int cycles;
        cycles = 0;
        status = '0;
        while (status[0] !== 1'b1) begin
            if (cycles >= 2000)
                fail_run("timeout waiting for done");
            apb_read(csr_paddr(CSR_STATUS), status);
            cycles += 2;
        end
    endtask

    task automatic run_matmul(input string name, input logic [7:0] ba, input logic [7:0] bb,
            input logic [7:0] bc, input logic [7:0] sa, input logic [7:0] sb,
            input logic [7:0] sc);
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] c_exp;
        cur_base_a   = ba;
        cur_base_b   = bb;
        cur_stride_a = sa;
        cur_stride_b = sb;
        for (int i = 0; i < MAT_DIM; i++) begin
            for (int k = 0; k < MAT_DIM; k++) begin
                sp_write(elem_addr(ba, sa, i, k), $random(seed));
                sp_write(elem_addr(bb, sb, i, k), $random(seed));
            end
        end
        apb_write(csr_paddr(CSR_MAT_A), ba);
        apb_write(csr_paddr(CSR_MAT_B), bb);
        apb_write(csr_paddr(CSR_MAT_C), bc);
        apb_write(csr_paddr(CSR_STRIDE_A), sa);
        apb_write(csr_paddr(CSR_STRIDE_B), sb);
        apb_write(csr_paddr(CSR_STRIDE_C), sc);
        apb_write(csr_paddr(CSR_START), 32'd1);
        // Busy set, done cleared
        apb_read(csr_paddr(CSR_STATUS), rd);
        expect_value({name, " status after start"}, 32'd2, rd);
        wait_done();
        for (int i = 0; i < MAT_DIM; i++) begin
            for (int j = 0; j < MAT_DIM; j++) begin
                c_exp = ref_matmul(i, j);
                apb_read(sp_paddr(elem_addr(bc, sc, i, j)), rd);
                expect_value($sformatf("%s c[%0d][%0d]", name, i, j), c_exp, rd);
                sp_model[elem_addr(bc, sc, i, j)] = c_exp;
            end
        end
        apb_read(csr_paddr(CSR_STATUS), rd);
        expect_value({name, " status after done"}, 32'd1, rd);
        // Operands untouched by the engine
        for (int i = 0; i < MAT_DIM; i++) begin
            for (int k = 0; k < MAT_DIM; k++) begin
                apb_read(sp_paddr(elem_addr(ba, sa, i, k)), rd);
                expect_value($sformatf("%s a[%0d][%0d]", name, i, k),
                             sp_model[elem_addr(ba, sa, i, k)], rd);
                apb_read(sp_paddr(elem_addr(bb, sb, i, k)), rd);
                expect_value($sformatf("%s b[%0d][%0d]", name, i, k),
                             sp_model[elem_addr(bb, sb, i, k)], rd);
            end
        end
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] wval [0:5];
        logic [SP_ADDR_W-1:0] addr;
        int drain;
        apb     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge apb);
        #1 reset = 1'b0;

        for (int idx = 0; idx < 8; idx++) begin
            apb_read(csr_paddr(idx), rd);
            expect_value($sformatf("reset csr %0d", idx), 32'd0, rd);
        end

        for (int idx = 0; idx < 6; idx++) begin
            wval[idx] = $random(seed);
            apb_write(csr_paddr(idx + 1), wval[idx]);
        end
        for (int idx = 0; idx < 6; idx++) begin
            apb_read(csr_paddr(idx + 1), rd);
            expect_value($sformatf("csr %0d readback", idx + 1), {24'b0, wval[idx][7:0]}, rd);
        end
        for (int idx = 8; idx < 16; idx++) begin
            apb_read(csr_paddr(idx), rd);
            expect_value($sformatf("unmapped csr %0d", idx), 32'd0, rd);
        end
        apb_read(csr_paddr(CSR_START), rd);
        expect_value("start readback", 32'd0, rd);

        for (int n = 0; n < 16; n++) begin
            addr = $random(seed);
            sp_write(addr, $random(seed));
            apb_read(sp_paddr(addr), rd);
            expect_value($sformatf("scratchpad word %h", addr), sp_model[addr], rd);
        end

        run_matmul("dense", 8'h00, 8'h20, 8'h40, 8'd4, 8'd4, 8'd4);
        // C wraps past the top of the scratchpad
        run_matmul("strided", 8'h90, 8'hb0, 8'hf0, 8'd7, 8'd9, 8'd6);

        drain = 0;
        while (exp_q.size() > 0 && drain < 10) begin
            @(posedge apb);
            drain++;
        end
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("compare queue did not drain");
        end
    end

endmodule

// File: compile.f
hw/mm_pkg.sv
hw/apb_csr.sv
hw/scratchpad.sv
hw/operand_feeder.sv
hw/mac_lane.sv
hw/result_writer.sv
hw/mm_accel_top.sv
verification/tb_mm_accel.sv
